//--- hdl/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int funct3W  = 3;
    localparam int immBitsW = 25;                       // Instruction bits 31 down to 7

    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opImm    = 7'b0010011,
        opAuipc  = 7'b0010111,
        opStore  = 7'b0100011,
        opReg    = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111
    } opcodeT;

    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ
    } immFormatT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra,
        aluPassB                                        // Forwards operand B, used by lui
    } aluOpT;

    typedef enum logic [1:0] {
        resAlu,
        resMem,
        resPcPlus4
    } resultSrcT;

    // funct3 codes of the integer ALU group
    localparam logic [funct3W-1:0] f3AddSub = 3'b000;
    localparam logic [funct3W-1:0] f3Sll    = 3'b001;
    localparam logic [funct3W-1:0] f3Slt    = 3'b010;
    localparam logic [funct3W-1:0] f3Sltu   = 3'b011;
    localparam logic [funct3W-1:0] f3Xor    = 3'b100;
    localparam logic [funct3W-1:0] f3SrlSra = 3'b101;
    localparam logic [funct3W-1:0] f3Or     = 3'b110;
    localparam logic [funct3W-1:0] f3And    = 3'b111;

endpackage

`default_nettype wire

//--- hdl/pipePkg.sv
`default_nettype none

package pipePkg;

    import isaPkg::*;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;
    localparam int numRegs  = 1 << regAddrW;
    localparam int a0Index  = 10;                       // Register x10 holds the return value

    // An all-zero control word is a bubble
    typedef struct packed {
        logic      jump;
        logic      branch;
        logic      regWrite;
        resultSrcT resultSrc;
        logic      memWrite;
        aluOpT     aluCtrl;
        logic      aluSrcA;                             // Set selects the PC as operand A
        logic      aluSrcB;                             // Set selects the immediate as operand B
    } ctrlT;

    typedef struct packed {
        ctrlT                ctrl;
        logic [xlen-1:0]     rd1;
        logic [xlen-1:0]     rd2;
        logic [xlen-1:0]     immExt;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     pcPlus4;
        logic [funct3W-1:0]  funct3;
        logic [regAddrW-1:0] rd;
        logic [regAddrW-1:0] rs1;
        logic [regAddrW-1:0] rs2;
    } decodedT;

    typedef struct packed {
        logic                regWrite;
        logic [regAddrW-1:0] rd;
        logic [xlen-1:0]     result;
    } wbWriteT;

endpackage

`default_nettype wire

//--- hdl/controlDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module controlDecoder import isaPkg::*, pipePkg::*; (
    input  logic [xlen-1:0] instr,
    input  logic            flush,
    input  logic            stallIn,
    output ctrlT            ctrl,
    output immFormatT       immFormat
);

    logic [funct3W-1:0] funct3;
    logic               funct7b5;
    ctrlT               mainCtrl;

    // Bit 30 only separates sub from add on register ops, but sra from srl on both
    function automatic aluOpT aluDecode(
        input logic [funct3W-1:0] f3,
        input logic               altOp,
        input logic               isReg
    );
        aluOpT op;
        case (f3)
            f3AddSub: op = (isReg && altOp) ? aluSub : aluAdd;
            f3Sll:    op = aluSll;
            f3Slt:    op = aluSlt;
            f3Sltu:   op = aluSltu;
            f3Xor:    op = aluXor;
            f3SrlSra: op = altOp ? aluSra : aluSrl;
            f3Or:     op = aluOr;
            f3And:    op = aluAnd;
            default:  op = aluAdd;
        endcase
        return op;
    endfunction

    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    always_comb begin
        mainCtrl  = '0;
        immFormat = immI;
        case (opcodeT'(instr[6:0]))
            opLoad: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.resultSrc = resMem;
                mainCtrl.aluCtrl   = aluAdd;                // Address is rs1 plus offset
                mainCtrl.aluSrcB   = 1'b1;
            end
            opStore: begin
                mainCtrl.memWrite  = 1'b1;
                mainCtrl.aluCtrl   = aluAdd;
                mainCtrl.aluSrcB   = 1'b1;
                immFormat          = immS;
            end
            opReg: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.aluCtrl   = aluDecode(funct3, funct7b5, 1'b1);
            end
            opImm: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.aluCtrl   = aluDecode(funct3, funct7b5, 1'b0);
                mainCtrl.aluSrcB   = 1'b1;
            end
            opLui: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.aluCtrl   = aluPassB;
                mainCtrl.aluSrcB   = 1'b1;
                immFormat          = immU;
            end
            opAuipc: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.aluCtrl   = aluAdd;
                mainCtrl.aluSrcA   = 1'b1;
                mainCtrl.aluSrcB   = 1'b1;
                immFormat          = immU;
            end
            opBranch: begin
                mainCtrl.branch    = 1'b1;
                mainCtrl.aluCtrl   = aluSub;                // Execute compares rs1 and rs2 by funct3
                immFormat          = immB;
            end
            opJal: begin
                mainCtrl.jump      = 1'b1;
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.resultSrc = resPcPlus4;
                mainCtrl.aluCtrl   = aluAdd;                // Target is PC plus offset
                mainCtrl.aluSrcA   = 1'b1;
                mainCtrl.aluSrcB   = 1'b1;
                immFormat          = immJ;
            end
            opJalr: begin
                mainCtrl.jump      = 1'b1;
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.resultSrc = resPcPlus4;
                mainCtrl.aluCtrl   = aluAdd;                // Target is rs1 plus offset
                mainCtrl.aluSrcB   = 1'b1;
            end
            default: begin
                mainCtrl = '0;                              // Unsupported opcodes become a bubble
            end
        endcase
    end

    assign ctrl = (flush || stallIn) ? '0 : mainCtrl;

endmodule

`default_nettype wire

//--- hdl/immExtender.sv
`timescale 1ns/10ps
`default_nettype none

module immExtender import isaPkg::*, pipePkg::*; (
    input  logic [immBitsW-1:0] instrBits,
    input  immFormatT           immFormat,
    output logic [xlen-1:0]     immExt
);

    logic sign;

    // instrBits[k] is instruction bit k+7
    assign sign = instrBits[24];

    always_comb begin
        case (immFormat)
            immI: begin
                immExt = {{20{sign}}, instrBits[24:13]};
            end
            immS: begin
                immExt = {{20{sign}}, instrBits[24:18], instrBits[4:0]};
            end
            immB: begin
                immExt = {{19{sign}}, sign, instrBits[0], instrBits[23:18],
                          instrBits[4:1], 1'b0};
            end
            immU: begin
                immExt = {instrBits[24:5], 12'b0};          // Upper immediate, no extension
            end
            immJ: begin
                immExt = {{11{sign}}, sign, instrBits[12:5], instrBits[13],
                          instrBits[23:14], 1'b0};
            end
            default: begin
                immExt = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile import pipePkg::*; (
    input  logic                clk,
    input  logic                arstN,
    input  logic [regAddrW-1:0] rs1,
    input  logic [regAddrW-1:0] rs2,
    input  wbWriteT             wb,
    output logic [xlen-1:0]     rd1,
    output logic [xlen-1:0]     rd2,
    output logic [xlen-1:0]     a0
);

    logic [xlen-1:0] regs [numRegs];
    logic            writeEn;

    assign writeEn = wb.regWrite && (wb.rd != '0);     // x0 is never written

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[wb.rd] <= wb.result;
        end
    end

    // No bypass from the write port, a same-cycle write shows up next cycle
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

    assign a0 = regs[a0Index];

endmodule

`default_nettype wire

//--- hdl/decodeExecuteReg.sv
`timescale 1ns/10ps
`default_nettype none

module decodeExecuteReg import pipePkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  logic    stallCache,
    input  decodedT decodedIn,
    output decodedT decodedOut
);

    // A cleared bundle carries a zero control word, so nothing commits after reset
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decodedOut <= '0;
        end else if (!stallCache) begin
            decodedOut <= decodedIn;                    // Hold everything while the cache stalls
        end
    end

endmodule

`default_nettype wire

//--- hdl/decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage import isaPkg::*, pipePkg::*; (
    input  logic                clk,
    input  logic                arstN,
    input  logic [xlen-1:0]     instrD,
    input  logic [xlen-1:0]     pcD,
    input  logic [xlen-1:0]     pcPlus4D,
    input  wbWriteT             wb,
    input  logic                flush,
    input  logic                stallIn,
    input  logic                stallCache,
    output decodedT             execE,
    output logic [regAddrW-1:0] rs1D,
    output logic [regAddrW-1:0] rs2D,
    output logic [xlen-1:0]     a0
);

    ctrlT            ctrlD;
    immFormatT       immFormatD;
    logic [xlen-1:0] immExtD;
    logic [xlen-1:0] rd1D;
    logic [xlen-1:0] rd2D;
    decodedT         decodedD;

    assign rs1D = instrD[19:15];
    assign rs2D = instrD[24:20];

    controlDecoder ctrlDec0 (
        .instr     (instrD),
        .flush     (flush),
        .stallIn   (stallIn),
        .ctrl      (ctrlD),
        .immFormat (immFormatD)
    );

    immExtender immExt0 (
        .instrBits (instrD[31:7]),
        .immFormat (immFormatD),
        .immExt    (immExtD)
    );

    regFile regFile0 (
        .clk   (clk),
        .arstN (arstN),
        .rs1   (rs1D),
        .rs2   (rs2D),
        .wb    (wb),
        .rd1   (rd1D),
        .rd2   (rd2D),
        .a0    (a0)
    );

    assign decodedD = '{
        ctrl:    ctrlD,
        rd1:     rd1D,
        rd2:     rd2D,
        immExt:  immExtD,
        pc:      pcD,
        pcPlus4: pcPlus4D,
        funct3:  instrD[14:12],
        rd:      instrD[11:7],
        rs1:     rs1D,
        rs2:     rs2D
    };

    decodeExecuteReg deReg0 (
        .clk        (clk),
        .arstN      (arstN),
        .stallCache (stallCache),
        .decodedIn  (decodedD),
        .decodedOut (execE)
    );

endmodule

`default_nettype wire

//--- testbench/decodeModel.svh
`ifndef decodeModelSvh
`define decodeModelSvh

// Reference decode, built from the RV32I base encoding tables

function automatic aluOpT expectedAlu(input logic [2:0] f3, input logic subSel,
                                      input logic sraSel);
    case (f3)
        3'b000:  return subSel ? aluSub : aluAdd;
        3'b001:  return aluSll;
        3'b010:  return aluSlt;
        3'b011:  return aluSltu;
        3'b100:  return aluXor;
        3'b101:  return sraSel ? aluSra : aluSrl;
        3'b110:  return aluOr;
        default: return aluAnd;
    endcase
endfunction

// A bubble or an opcode outside the supported set gives an all-zero word
function automatic ctrlT expectedCtrl(input logic [31:0] instr, input logic bubble);
    ctrlT       c;
    logic [6:0] op;
    logic       known;
    op    = instr[6:0];
    known = (op == opLoad) || (op == opImm) || (op == opAuipc) || (op == opStore)
         || (op == opReg) || (op == opLui) || (op == opBranch) || (op == opJalr)
         || (op == opJal);
    c          = '0;
    c.jump     = (op == opJal) || (op == opJalr);
    c.branch   = (op == opBranch);
    c.memWrite = (op == opStore);
    c.regWrite = !c.branch && !c.memWrite;
    c.aluSrcA  = (op == opAuipc) || (op == opJal);      // Both add an offset to the PC
    c.aluSrcB  = (op != opReg) && (op != opBranch);
    if (op == opLoad)
        c.resultSrc = resMem;
    else if (c.jump)
        c.resultSrc = resPcPlus4;
    else
        c.resultSrc = resAlu;
    if (op == opLui)
        c.aluCtrl = aluPassB;
    else if (op == opReg)
        c.aluCtrl = expectedAlu(instr[14:12], instr[30], instr[30]);
    else if (op == opImm)
        c.aluCtrl = expectedAlu(instr[14:12], 1'b0, instr[30]);  // There is no subi
    else if (op == opBranch)
        c.aluCtrl = aluSub;
    else
        c.aluCtrl = aluAdd;
    if (bubble || !known)
        c = '0;
    return c;
endfunction

function automatic logic [31:0] expectedImm(input logic [31:0] instr);
    logic [6:0] op;
    op = instr[6:0];
    if (op == opStore)
        return {{20{instr[31]}}, instr[31:25], instr[11:7]};
    else if (op == opBranch)
        return {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    else if ((op == opLui) || (op == opAuipc))
        return {instr[31:12], 12'h000};
    else if (op == opJal)
        return {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    else
        return {{20{instr[31]}}, instr[31:20]};         // I format, also for R and unknown
endfunction

`endif

//--- testbench/decodeStageTb.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStageTb import isaPkg::*, pipePkg::*; ();

    localparam int resetLen   = 12;
    localparam int regLen     = 48;
    localparam int sweepLen   = 90;                     // Ten of each supported opcode
    localparam int unknownLen = 16;
    localparam int bubbleLen  = 18;
    localparam int stallLen   = 6;
    localparam int cycleLimit = 2 * (resetLen + regLen + sweepLen + unknownLen + bubbleLen
                                     + stallLen + 8);

    logic                clk = 1'b0;
    logic                arstN;
    logic [xlen-1:0]     instrD;
    logic [xlen-1:0]     pcD;
    logic [xlen-1:0]     pcPlus4D;
    wbWriteT             wb;
    logic                flush;
    logic                stallIn;
    logic                stallCache;
    decodedT             execE;
    logic [regAddrW-1:0] rs1D;
    logic [regAddrW-1:0] rs2D;
    logic [xlen-1:0]     a0;
    decodedT             expE;
    logic [xlen-1:0]     shadow [numRegs];
    int                  errCount   = 0;
    int                  errMark    = 0;
    int                  passCount  = 0;
    int                  failCount  = 0;
    int                  cycleCount = 0;

    `include "decodeModel.svh"

    decodeStage dut0 (
        .clk        (clk),
        .arstN      (arstN),
        .instrD     (instrD),
        .pcD        (pcD),
        .pcPlus4D   (pcPlus4D),
        .wb         (wb),
        .flush      (flush),
        .stallIn    (stallIn),
        .stallCache (stallCache),
        .execE      (execE),
        .rs1D       (rs1D),
        .rs2D       (rs2D),
        .a0         (a0)
    );

    always #20 clk = ~clk;

    function automatic decodedT expectedBundle();
        decodedT e;
        e.ctrl    = expectedCtrl(instrD, flush || stallIn);
        e.rd1     = shadow[instrD[19:15]];              // shadow[0] is never written
        e.rd2     = shadow[instrD[24:20]];
        e.immExt  = expectedImm(instrD);
        e.pc      = pcD;
        e.pcPlus4 = pcPlus4D;
        e.funct3  = instrD[14:12];
        e.rd      = instrD[11:7];
        e.rs1     = instrD[19:15];
        e.rs2     = instrD[24:20];
        return e;
    endfunction

    // Expected contents of the execute register and of the register file
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            expE <= '0;
            for (int i = 0; i < numRegs; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            if (!stallCache) begin
                expE <= expectedBundle();
            end
            if (wb.regWrite && (wb.rd != '0)) begin
                shadow[wb.rd] <= wb.result;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the tests did not finish within %0d cycles", cycleLimit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic reportMismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] want);
        errCount++;
        $display("MISMATCH %s at %0t: got %h, expected %h", name, $time, got, want);
    endtask

    // Outputs settle well before the falling edge
    ctrlChk: assert property (@(negedge clk) execE.ctrl == expE.ctrl)
        else reportMismatch("execE.ctrl", 64'(execE.ctrl), 64'(expE.ctrl));
    rd1Chk: assert property (@(negedge clk) execE.rd1 == expE.rd1)
        else reportMismatch("execE.rd1", 64'(execE.rd1), 64'(expE.rd1));
    rd2Chk: assert property (@(negedge clk) execE.rd2 == expE.rd2)
        else reportMismatch("execE.rd2", 64'(execE.rd2), 64'(expE.rd2));
    immChk: assert property (@(negedge clk) execE.immExt == expE.immExt)
        else reportMismatch("execE.immExt", 64'(execE.immExt), 64'(expE.immExt));
    pcChk: assert property (@(negedge clk) execE.pc == expE.pc)
        else reportMismatch("execE.pc", 64'(execE.pc), 64'(expE.pc));
    pcPlus4Chk: assert property (@(negedge clk) execE.pcPlus4 == expE.pcPlus4)
        else reportMismatch("execE.pcPlus4", 64'(execE.pcPlus4), 64'(expE.pcPlus4));
    fieldChk: assert property (@(negedge clk)
            {execE.funct3, execE.rd, execE.rs1, execE.rs2}
            == {expE.funct3, expE.rd, expE.rs1, expE.rs2})
        else reportMismatch("execE.{funct3,rd,rs1,rs2}",
            64'({execE.funct3, execE.rd, execE.rs1, execE.rs2}),
            64'({expE.funct3, expE.rd, expE.rs1, expE.rs2}));
    a0Chk: assert property (@(negedge clk) a0 == shadow[a0Index])
        else reportMismatch("a0", 64'(a0), 64'(shadow[a0Index]));
    rsChk: assert property (@(negedge clk) {rs1D, rs2D} == {instrD[19:15], instrD[24:20]})
        else reportMismatch("{rs1D,rs2D}", 64'({rs1D, rs2D}),
            64'({instrD[19:15], instrD[24:20]}));

    function automatic logic [31:0] randomWord();
        return $urandom;
    endfunction

    function automatic opcodeT supportedOp(input int k);
        case (k)
            0:       return opLoad;
            1:       return opImm;
            2:       return opAuipc;
            3:       return opStore;
            4:       return opReg;
            5:       return opLui;
            6:       return opBranch;
            7:       return opJalr;
            default: return opJal;
        endcase
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic driveInstr(input logic [31:0] instr);
        logic [31:0] r;
        r        = randomWord();
        instrD   = instr;
        pcD      = {r[31:2], 2'b00};
        pcPlus4D = pcD + 32'd4;
    endtask

    // One more edge captures the last instruction and the falling edge checks it
    task automatic finishTest(input string name);
        nextCycle();
        @(negedge clk);
        #1;
        if (errCount == errMark) begin
            passCount++;
            $display("Test %s done, no mismatches", name);
        end else begin
            failCount++;
            $display("Test %s done, %0d mismatches", name, errCount - errMark);
        end
        errMark = errCount;
        nextCycle();                                    // The next test drives after a rising edge
    endtask

    task automatic resetTest();
        arstN = 1'b0;
        repeat (resetLen - 2) begin
            driveInstr(randomWord());                   // Must not reach execE under reset
            nextCycle();
        end
        arstN    = 1'b1;
        instrD   = '0;
        pcD      = '0;
        pcPlus4D = '0;
        repeat (2) nextCycle();
        finishTest("reset");
    endtask

    task automatic regTest();
        logic [31:0]         r;
        logic [regAddrW-1:0] lastRd;
        lastRd = '0;
        for (int i = 0; i < regLen; i++) begin
            r           = randomWord();
            wb.regWrite = (i % 6 != 5);
            wb.rd       = (i % 8 == 0) ? 5'd0 : (i % 8 == 1) ? 5'(a0Index) : r[4:0];
            wb.result   = randomWord();
            // rs2 now and then names the register written in this same cycle
            driveInstr({r[31:25], (i % 4 == 2) ? wb.rd : r[24:20], lastRd, r[14:12],
                        r[11:7], opReg});
            lastRd = wb.rd;
            nextCycle();
        end
        wb = '0;
        finishTest("register file");
    endtask

    task automatic sweepTest();
        logic [31:0] r;
        for (int i = 0; i < sweepLen + unknownLen; i++) begin
            r = randomWord();
            if (i < sweepLen)
                driveInstr({r[31:7], supportedOp(i % 9)});
            else
                driveInstr({r[31:2], 2'b01});           // Low bits 01 are never RV32I
            nextCycle();
        end
        finishTest("decode sweep");
    endtask

    task automatic bubbleTest();
        logic [31:0] r;
        for (int i = 0; i < bubbleLen; i++) begin
            r       = randomWord();
            flush   = (i % 3 == 0);
            stallIn = (i % 3 == 1);
            driveInstr({r[31:7], supportedOp(int'(r % 32'd9))});
            nextCycle();
        end
        flush   = 1'b0;
        stallIn = 1'b0;
        finishTest("bubble insertion");
    endtask

    task automatic stallTest();
        logic [31:0] r;
        r = randomWord();
        driveInstr({r[31:7], opJal});
        nextCycle();
        stallCache = 1'b1;
        for (int i = 0; i < stallLen; i++) begin
            r           = randomWord();
            wb.regWrite = 1'b1;                         // Writeback keeps going during the stall
            wb.rd       = (i == stallLen - 1) ? 5'(a0Index) : r[4:0];  // The last one hits a0
            wb.result   = randomWord();
            driveInstr({r[31:7], supportedOp(i)});
            nextCycle();
        end
        stallCache = 1'b0;
        wb         = '0;
        r          = randomWord();
        driveInstr({r[31:7], opStore});
        finishTest("cache stall");
    endtask

    initial begin
        void'($urandom(32'h4e79));
        arstN      = 1'b1;
        instrD     = '0;
        pcD        = '0;
        pcPlus4D   = '0;
        wb         = '0;
        flush      = 1'b0;
        stallIn    = 1'b0;
        stallCache = 1'b0;
        #1;
        resetTest();
        regTest();
        sweepTest();
        bubbleTest();
        stallTest();
        $display("Tests passed: %0d, failed: %0d, mismatches: %0d",
                 passCount, failCount, errCount);
        if ((failCount == 0) && (errCount == 0))
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+testbench
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/controlDecoder.sv
hdl/immExtender.sv
hdl/regFile.sv
hdl/decodeExecuteReg.sv
hdl/decodeStage.sv
testbench/decodeStageTb.sv

//--- Makefile
TOP := decodeStageTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the result"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --assert -j 0 --top-module $(TOP) -f filelist.f --Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
